//--- sim.f
hw/cia_pkg.sv
hw/cia_apb_decode.sv
hw/cia_io_ports.sv
hw/cia_timers.sv
hw/cia_tod.sv
hw/cia_irq_ctrl.sv
hw/cia_top.sv
tb/cia_tb.sv

//--- tb/cia_tb.sv
// ====================
// Testbench for cia_top, one APB transfer at a time
// Any failed check stops the run at once
// tod and flag_n are driven slowly against clk
// ====================
`timescale 1ns/1ps

module cia_tb;

  logic        clk;
  logic        int_reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;
  logic [7:0]  pa_in;
  logic [7:0]  pa_out;
  logic [7:0]  pb_in;
  logic [7:0]  pb_out;
  logic        flag_n;
  logic        pc;
  logic        cnt;
  logic        tod;
  logic        irq;
  logic [31:0] rnd;
  integer      seed;
  logic        irq_quiet;
  logic        prb_access;

  cia_top uut (
    .clk(clk), .int_reset(int_reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready),
    .pa_in(pa_in), .pa_out(pa_out), .pb_in(pb_in), .pb_out(pb_out),
    .flag_n(flag_n), .pc(pc), .cnt(cnt), .tod(tod), .irq(irq)
  );

  // First access cycle of a PRB transfer
  assign prb_access = psel && penable && !pready && paddr == cia_pkg::REG_PRB;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
    $display("CHECK FAILED at %0d ns: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0d ns: %s", $time, what);
    abort_run();
  endtask

  task automatic expect_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got == exp) else report_mismatch(name, got, exp);
  endtask

  task automatic apb_transfer(input logic write, input logic [3:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
    int waited;
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    waited  = 0;
    @(negedge clk);
    while (!pready) begin
      waited++;
      if (waited > 8) report_timeout("pready never rose during an APB transfer");
      @(negedge clk);
    end
    rdata = prdata;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [7:0] data);
    logic [7:0] unused_rd;
    apb_transfer(1'b1, addr, data, unused_rd);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [7:0] data);
    apb_transfer(1'b0, addr, 8'h00, data);
  endtask

  task automatic read_expect(input logic [3:0] addr, input logic [7:0] exp, input string name);
    logic [7:0] got;
    apb_read(addr, got);
    expect_byte(name, got, exp);
  endtask

  task automatic wait_irq(input string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!irq) begin
      waited++;
      if (waited > 400) report_timeout(what);
      @(negedge clk);
    end
  endtask

  // Poll CRA until the one-shot clears its start bit
  task automatic wait_oneshot_done();
    logic [7:0] cr;
    int         polls;
    polls = 0;
    apb_read(cia_pkg::REG_CRA, cr);
    while (cr[cia_pkg::CR_START]) begin
      expect_byte("CRA load bit", {3'b000, cr[cia_pkg::CR_LOAD], 4'h0}, 8'h00);
      polls++;
      if (polls > 20) report_timeout("timer A one-shot never stopped");
      apb_read(cia_pkg::REG_CRA, cr);
    end
    expect_byte("CRA after one-shot", cr, 8'h08);
  endtask

  task automatic tod_edges(input int n);
    repeat (n) begin
      repeat (2) @(posedge clk);
      #2 tod = 1'b1;
      repeat (2) @(posedge clk);
      #2 tod = 1'b0;
    end
  endtask

  // APB timing and PC handshake
  assert property (@(posedge clk) disable iff (int_reset) psel && !penable |=> !pready)
    else report_mismatch("pready in first access cycle", 8'h01, 8'h00);
  assert property (@(posedge clk) disable iff (int_reset) psel && !penable |=> ##1 pready)
    else report_mismatch("pready in second access cycle", 8'h00, 8'h01);
  assert property (@(posedge clk) disable iff (int_reset) psel && !penable |=> ##2 !pready)
    else report_mismatch("pready after transfer", 8'h01, 8'h00);
  assert property (@(posedge clk) disable iff (int_reset) prb_access |=> pc)
    else report_mismatch("pc after PRB access", 8'h00, 8'h01);
  assert property (@(posedge clk) disable iff (int_reset) pc |=> !pc)
    else report_mismatch("pc second cycle", 8'h01, 8'h00);
  assert property (@(posedge clk) disable iff (int_reset) pc |-> $past(prb_access))
    else report_mismatch("pc without PRB access", 8'h01, 8'h00);
  assert property (@(posedge clk) disable iff (int_reset) irq_quiet |-> !irq)
    else report_mismatch("irq with mask clear", 8'h01, 8'h00);

  initial begin
    seed      = 32'haeabd042;
    int_reset = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = 4'h0;
    pwdata    = 8'h00;
    pa_in     = 8'h00;
    pb_in     = 8'h00;
    flag_n    = 1'b1;
    cnt       = 1'b0;
    tod       = 1'b0;
    irq_quiet = 1'b0;
    repeat (16) @(posedge clk);
    #2 int_reset = 1'b0;

    expect_byte("pa_out after reset", pa_out, 8'hFF);
    expect_byte("pb_out after reset", pb_out, 8'hFF);
    expect_byte("irq after reset", {7'h00, irq}, 8'h00);
    expect_byte("pc after reset", {7'h00, pc}, 8'h00);
    expect_byte("pready after reset", {7'h00, pready}, 8'h00);
    read_expect(cia_pkg::REG_TA_HI, 8'hFF, "TA_HI after reset");
    read_expect(cia_pkg::REG_TOD_HR, 8'h01, "TOD hour after reset");
    read_expect(cia_pkg::REG_TOD_10THS, 8'h00, "TOD tenths after reset");

    // Ports
    rnd   = $random(seed);
    pa_in = rnd[7:0];
    rnd   = $random(seed);
    pb_in = rnd[7:0];
    apb_write(cia_pkg::REG_DDRA, 8'h0F);
    apb_write(cia_pkg::REG_PRA, 8'h05);
    expect_byte("pa_out", pa_out, 8'hF5);
    apb_write(cia_pkg::REG_DDRB, 8'hA5);
    apb_write(cia_pkg::REG_PRB, 8'h3C);
    expect_byte("pb_out", pb_out, 8'h7E);
    read_expect(cia_pkg::REG_PRA, pa_in, "PRA pins");
    read_expect(cia_pkg::REG_PRB, pb_in, "PRB pins");
    read_expect(cia_pkg::REG_DDRA, 8'h0F, "DDRA");
    read_expect(cia_pkg::REG_DDRB, 8'hA5, "DDRB");

    // Timer A one-shot, period of 10 clocks
    apb_write(cia_pkg::REG_TA_LO, 8'h09);
    apb_write(cia_pkg::REG_TA_HI, 8'h00);
    apb_write(cia_pkg::REG_CRA, 8'h19);
    wait_oneshot_done();
    read_expect(cia_pkg::REG_ICR, 8'h01, "ICR after one-shot");

    // Masked flag must not reach irq
    apb_write(cia_pkg::REG_TA_LO, 8'h05);
    apb_write(cia_pkg::REG_TA_HI, 8'h00);
    irq_quiet = 1'b1;
    apb_write(cia_pkg::REG_CRA, 8'h19);
    wait_oneshot_done();
    expect_byte("irq with mask clear", {7'h00, irq}, 8'h00);
    irq_quiet = 1'b0;
    apb_write(cia_pkg::REG_ICR, 8'h81);
    wait_irq("irq did not rise after the TA mask was set");
    read_expect(cia_pkg::REG_ICR, 8'h81, "ICR with TA mask");
    expect_byte("irq after ICR read", {7'h00, irq}, 8'h00);
    read_expect(cia_pkg::REG_ICR, 8'h00, "ICR second read");

    // Timer B counts timer A underflows
    apb_write(cia_pkg::REG_TB_LO, 8'h00);
    apb_write(cia_pkg::REG_TB_HI, 8'h10);
    apb_write(cia_pkg::REG_CRB, 8'h41);
    apb_write(cia_pkg::REG_TA_LO, 8'h40);
    apb_write(cia_pkg::REG_TA_HI, 8'h00);
    apb_write(cia_pkg::REG_CRA, 8'h11);
    for (int i = 0; i < 3; i++) begin
      wait_irq("timer A underflow did not raise irq");
      read_expect(cia_pkg::REG_ICR, 8'h81, "ICR on timer A underflow");
    end
    apb_write(cia_pkg::REG_CRA, 8'h00);
    read_expect(cia_pkg::REG_TB_LO, 8'hFD, "TB_LO after cascade");
    read_expect(cia_pkg::REG_TB_HI, 8'h0F, "TB_HI after cascade");

    // TOD 11:59:59.9 AM rolls to 12:00:00.0 PM
    apb_write(cia_pkg::REG_TOD_HR, 8'h11);
    apb_write(cia_pkg::REG_TOD_MIN, 8'h59);
    apb_write(cia_pkg::REG_TOD_SEC, 8'h59);
    apb_write(cia_pkg::REG_TOD_10THS, 8'h09);
    tod_edges(6);
    read_expect(cia_pkg::REG_TOD_HR, 8'h92, "TOD hour at noon");
    read_expect(cia_pkg::REG_TOD_MIN, 8'h00, "TOD minutes at noon");
    read_expect(cia_pkg::REG_TOD_SEC, 8'h00, "TOD seconds at noon");
    read_expect(cia_pkg::REG_TOD_10THS, 8'h00, "TOD tenths at noon");

    // 12:59:59.9 PM rolls to 01:00:00.0 PM
    apb_write(cia_pkg::REG_TOD_HR, 8'h92);
    apb_write(cia_pkg::REG_TOD_MIN, 8'h59);
    apb_write(cia_pkg::REG_TOD_SEC, 8'h59);
    apb_write(cia_pkg::REG_TOD_10THS, 8'h09);
    tod_edges(6);
    read_expect(cia_pkg::REG_TOD_HR, 8'h81, "TOD hour at one");
    read_expect(cia_pkg::REG_TOD_MIN, 8'h00, "TOD minutes at one");
    read_expect(cia_pkg::REG_TOD_SEC, 8'h00, "TOD seconds at one");
    read_expect(cia_pkg::REG_TOD_10THS, 8'h00, "TOD tenths at one");

    // Read latch holds across a minute change
    apb_write(cia_pkg::REG_TOD_HR, 8'h81);
    apb_write(cia_pkg::REG_TOD_MIN, 8'h00);
    apb_write(cia_pkg::REG_TOD_SEC, 8'h59);
    apb_write(cia_pkg::REG_TOD_10THS, 8'h09);
    read_expect(cia_pkg::REG_TOD_HR, 8'h81, "TOD hour latched");
    tod_edges(6);
    read_expect(cia_pkg::REG_TOD_MIN, 8'h00, "TOD minutes while latched");
    read_expect(cia_pkg::REG_TOD_10THS, 8'h09, "TOD tenths while latched");
    read_expect(cia_pkg::REG_TOD_MIN, 8'h01, "TOD minutes after release");
    read_expect(cia_pkg::REG_TOD_SEC, 8'h00, "TOD seconds after release");

    // Alarm at 01:01:00.1 PM, tenths written first
    apb_write(cia_pkg::REG_CRB, 8'hC1);
    apb_write(cia_pkg::REG_TOD_10THS, 8'h01);
    apb_write(cia_pkg::REG_TOD_SEC, 8'h00);
    apb_write(cia_pkg::REG_TOD_MIN, 8'h01);
    apb_write(cia_pkg::REG_TOD_HR, 8'h81);
    apb_write(cia_pkg::REG_CRB, 8'h41);
    read_expect(cia_pkg::REG_ICR, 8'h00, "ICR before alarm");
    apb_write(cia_pkg::REG_ICR, 8'h84);
    tod_edges(6);
    wait_irq("alarm did not raise irq");
    read_expect(cia_pkg::REG_ICR, 8'h84, "ICR on alarm");

    // FLAG falling edge
    apb_write(cia_pkg::REG_ICR, 8'h90);
    @(posedge clk);
    #2 flag_n = 1'b0;
    wait_irq("FLAG edge did not raise irq");
    read_expect(cia_pkg::REG_ICR, 8'h90, "ICR on FLAG");
    @(posedge clk);
    #2 flag_n = 1'b1;
    repeat (4) @(posedge clk);

    $display("Everything OK");
    $finish;
  end

endmodule

//--- hw/cia_top.sv
// ====================
// 6526-style adapter on APB, single clock domain
// No serial port, CNT output or timer PB outputs
// ====================
`timescale 1ns/1ps

module cia_top (
  input  logic       clk,
  input  logic       int_reset,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  logic [3:0] paddr,
  input  logic [7:0] pwdata,
  output logic [7:0] prdata,
  output logic       pready,
  input  logic [7:0] pa_in,
  output logic [7:0] pa_out,
  input  logic [7:0] pb_in,
  output logic [7:0] pb_out,
  input  logic       flag_n,
  output logic       pc,
  input  logic       cnt,
  input  logic       tod,
  output logic       irq
);

  cia_pkg::reg_access_t access;
  cia_pkg::irq_events_t events;
  logic [7:0]           port_rdata;
  logic [7:0]           timer_rdata;
  logic [7:0]           tod_rdata;
  logic [7:0]           icr_rdata;
  logic [7:0]           cra;
  logic [7:0]           crb;

  cia_apb_decode u_decode (
    .clk(clk), .int_reset(int_reset),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .access(access),
    .port_rdata(port_rdata), .timer_rdata(timer_rdata),
    .tod_rdata(tod_rdata), .icr_rdata(icr_rdata)
  );

  cia_io_ports u_ports (
    .clk(clk), .int_reset(int_reset), .access(access),
    .pa_in(pa_in), .pb_in(pb_in), .pa_out(pa_out), .pb_out(pb_out),
    .flag_n(flag_n), .pc(pc), .rdata(port_rdata), .flag_event(events.flag)
  );

  cia_timers u_timers (
    .clk(clk), .int_reset(int_reset), .access(access), .cnt(cnt),
    .cra(cra), .crb(crb), .rdata(timer_rdata),
    .ta_event(events.ta), .tb_event(events.tb)
  );

  cia_tod u_tod (
    .clk(clk), .int_reset(int_reset), .access(access), .tod(tod),
    .tod_50hz(cra[cia_pkg::CRA_TOD_50HZ]), .alarm_sel(crb[cia_pkg::CRB_ALARM]),
    .rdata(tod_rdata), .alarm_event(events.alarm)
  );

  cia_irq_ctrl u_irq (
    .clk(clk), .int_reset(int_reset), .access(access), .events(events),
    .rdata(icr_rdata), .irq(irq)
  );

endmodule

//--- hw/cia_irq_ctrl.sv
// ====================
// Interrupt flags and mask, read of ICR clears the flags
// Bit 3 (serial port) never sets
// ====================
`timescale 1ns/1ps

module cia_irq_ctrl (
  input  logic                 clk,
  input  logic                 int_reset,
  input  cia_pkg::reg_access_t access,
  input  cia_pkg::irq_events_t events,
  output logic [7:0]           rdata,
  output logic                 irq
);

  logic [cia_pkg::IRQ_SOURCES-1:0] flags;
  logic [cia_pkg::IRQ_SOURCES-1:0] mask;
  logic [cia_pkg::IRQ_SOURCES-1:0] ev;
  cia_pkg::icr_word_u              icr_in;
  cia_pkg::icr_word_u              icr_out;
  logic                            icr_wr;
  logic                            icr_rd;

  assign icr_wr = access.wr && access.addr == cia_pkg::REG_ICR;
  assign icr_rd = access.rd && access.addr == cia_pkg::REG_ICR;
  assign icr_in = access.wdata;

  always_comb begin
    ev                     = '0;
    ev[cia_pkg::IRQ_TA]    = events.ta;
    ev[cia_pkg::IRQ_TB]    = events.tb;
    ev[cia_pkg::IRQ_ALARM] = events.alarm;
    ev[cia_pkg::IRQ_FLAG]  = events.flag;
  end

  always_comb begin
    icr_out.rd.irq    = irq;
    icr_out.rd.unused = 2'b00;
    icr_out.rd.flags  = flags;
  end

  assign rdata = (access.addr == cia_pkg::REG_ICR) ? icr_out : 8'h00;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      flags <= '0;
      mask  <= '0;
      irq   <= 1'b0;
    end else begin
      // A new event survives a clearing read
      flags <= (icr_rd ? '0 : flags) | ev;
      irq   <= icr_rd ? 1'b0 : |(flags & mask);
      if (icr_wr) begin
        if (icr_in.wr.set_clr) mask <= mask | icr_in.wr.mask;
        else mask <= mask & ~icr_in.wr.mask;
      end
    end
  end

  assert property (@(posedge clk) disable iff (int_reset)
    irq |-> $past(|(flags & mask)));

endmodule

//--- hw/cia_tod.sv
// ====================
// BCD time-of-day clock, 12 hour format, PM in hour bit 7
// tod is sampled on clk, so it must be much slower
// Hour write stops the clock, tenths write restarts it
// ====================
`timescale 1ns/1ps

module cia_tod (
  input  logic                 clk,
  input  logic                 int_reset,
  input  cia_pkg::reg_access_t access,
  input  logic                 tod,
  input  logic                 tod_50hz,
  input  logic                 alarm_sel,
  output logic [7:0]           rdata,
  output logic                 alarm_event
);

  logic [3:0]  tenths;
  logic [6:0]  sec;
  logic [6:0]  min;
  logic [4:0]  hr;
  logic        pm;
  logic        run;
  logic        tod_d;
  logic [2:0]  div_cnt;
  logic [2:0]  div_limit;
  logic        tick;
  logic [23:0] live;
  logic [23:0] alarm;
  logic [23:0] latch;
  logic        latched;
  logic [23:0] rd_src;
  logic        match;
  logic        match_d;

  function automatic logic [6:0] bcd_inc(input logic [6:0] v);
    if (v[3:0] == 4'h9) return {v[6:4] + 3'd1, 4'h0};
    return {v[6:4], v[3:0] + 4'd1};
  endfunction

  assign live      = {pm, hr, min, sec, tenths};
  assign div_limit = tod_50hz ? cia_pkg::TOD_DIV_50 : cia_pkg::TOD_DIV_60;
  assign tick      = run & tod & ~tod_d & (div_cnt == div_limit - 3'd1);

  assign match       = live == alarm;
  assign alarm_event = match & ~match_d;

  assign rd_src = latched ? latch : live;

  always_comb begin
    case (access.addr)
      cia_pkg::REG_TOD_10THS: rdata = {4'h0, rd_src[3:0]};
      cia_pkg::REG_TOD_SEC:   rdata = {1'b0, rd_src[10:4]};
      cia_pkg::REG_TOD_MIN:   rdata = {1'b0, rd_src[17:11]};
      cia_pkg::REG_TOD_HR:    rdata = {rd_src[23], 2'b00, rd_src[22:18]};
      default:                rdata = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      tenths  <= 4'h0;
      sec     <= 7'h00;
      min     <= 7'h00;
      hr      <= 5'h01;
      pm      <= 1'b0;
      run     <= 1'b0;
      tod_d   <= 1'b0;
      div_cnt <= 3'd0;
      alarm   <= 24'h000000;
      latched <= 1'b0;
      match_d <= 1'b0;
    end else begin
      tod_d   <= tod;
      match_d <= match;
      if (!run) div_cnt <= 3'd0;
      else if (tick) div_cnt <= 3'd0;
      else if (tod && !tod_d) div_cnt <= div_cnt + 3'd1;

      if (tick) begin
        if (tenths != 4'h9) begin
          tenths <= tenths + 4'd1;
        end else begin
          tenths <= 4'h0;
          if (sec != 7'h59) begin
            sec <= bcd_inc(sec);
          end else begin
            sec <= 7'h00;
            if (min != 7'h59) begin
              min <= bcd_inc(min);
            end else begin
              min <= 7'h00;
              // 11 -> 12 flips AM/PM, 12 -> 01 keeps it
              if (hr == 5'h11) begin
                hr <= 5'h12;
                pm <= ~pm;
              end else if (hr == 5'h12) begin
                hr <= 5'h01;
              end else begin
                hr <= 5'(bcd_inc({2'b00, hr}));
              end
            end
          end
        end
      end

      if (access.rd && access.addr == cia_pkg::REG_TOD_HR) begin
        latched <= 1'b1;
      end else if (access.rd && access.addr == cia_pkg::REG_TOD_10THS) begin
        latched <= 1'b0;
      end

      if (access.wr && alarm_sel) begin
        case (access.addr)
          cia_pkg::REG_TOD_10THS: alarm[3:0]   <= access.wdata[3:0];
          cia_pkg::REG_TOD_SEC:   alarm[10:4]  <= access.wdata[6:0];
          cia_pkg::REG_TOD_MIN:   alarm[17:11] <= access.wdata[6:0];
          cia_pkg::REG_TOD_HR:    alarm[23:18] <= {access.wdata[7], access.wdata[4:0]};
          default: ;
        endcase
      end else if (access.wr) begin
        case (access.addr)
          cia_pkg::REG_TOD_10THS: begin
            tenths  <= access.wdata[3:0];
            run     <= 1'b1;
            div_cnt <= 3'd0;
          end
          cia_pkg::REG_TOD_SEC: sec <= access.wdata[6:0];
          cia_pkg::REG_TOD_MIN: min <= access.wdata[6:0];
          cia_pkg::REG_TOD_HR: begin
            hr  <= access.wdata[4:0];
            pm  <= access.wdata[7];
            run <= 1'b0;
          end
          default: ;
        endcase
      end
    end
  end

  // Snapshot taken by the hour read
  always_ff @(posedge clk) begin
    if (access.rd && access.addr == cia_pkg::REG_TOD_HR && !latched) latch <= live;
  end

endmodule

//--- hw/cia_timers.sv
// ====================
// Interval timers A and B, 16 bits each
// No PB6/PB7 outputs; B may count A underflows
// Period is latch + 1 count events
// ====================
`timescale 1ns/1ps

module cia_timers (
  input  logic                 clk,
  input  logic                 int_reset,
  input  cia_pkg::reg_access_t access,
  input  logic                 cnt,
  output logic [7:0]           cra,
  output logic [7:0]           crb,
  output logic [7:0]           rdata,
  output logic                 ta_event,
  output logic                 tb_event
);

  logic [7:0]  cr_q  [2];
  logic [15:0] latch [2];
  logic [15:0] count [2];
  logic        cnt_d;
  logic        cnt_rise;
  logic        src_b;
  logic [1:0]  tick;
  logic [1:0]  under;
  logic [1:0]  wr_lo;
  logic [1:0]  wr_hi;
  logic [1:0]  wr_cr;

  assign cnt_rise = cnt & ~cnt_d;

  assign wr_lo = {access.wr && access.addr == cia_pkg::REG_TB_LO,
                  access.wr && access.addr == cia_pkg::REG_TA_LO};
  assign wr_hi = {access.wr && access.addr == cia_pkg::REG_TB_HI,
                  access.wr && access.addr == cia_pkg::REG_TA_HI};
  assign wr_cr = {access.wr && access.addr == cia_pkg::REG_CRB,
                  access.wr && access.addr == cia_pkg::REG_CRA};

  always_comb begin
    tick[0]  = cr_q[0][cia_pkg::CR_START] &
               (cr_q[0][cia_pkg::CR_INMODE_LO] ? cnt_rise : 1'b1);
    under[0] = tick[0] & (count[0] == 16'h0000);
    case ({cr_q[1][cia_pkg::CRB_INMODE_HI], cr_q[1][cia_pkg::CR_INMODE_LO]})
      2'b00:   src_b = 1'b1;
      2'b01:   src_b = cnt_rise;
      2'b10:   src_b = under[0];
      default: src_b = under[0] & cnt;
    endcase
    tick[1]  = cr_q[1][cia_pkg::CR_START] & src_b;
    under[1] = tick[1] & (count[1] == 16'h0000);
  end

  assign ta_event = under[0];
  assign tb_event = under[1];
  assign cra      = cr_q[0];
  assign crb      = cr_q[1];

  always_comb begin
    case (access.addr)
      cia_pkg::REG_TA_LO: rdata = count[0][7:0];
      cia_pkg::REG_TA_HI: rdata = count[0][15:8];
      cia_pkg::REG_TB_LO: rdata = count[1][7:0];
      cia_pkg::REG_TB_HI: rdata = count[1][15:8];
      cia_pkg::REG_CRA:   rdata = cr_q[0];
      cia_pkg::REG_CRB:   rdata = cr_q[1];
      default:            rdata = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      for (int i = 0; i < 2; i++) begin
        cr_q[i]  <= 8'h00;
        latch[i] <= 16'hFFFF;
        count[i] <= 16'hFFFF;
      end
      cnt_d <= 1'b0;
    end else begin
      cnt_d <= cnt;
      for (int i = 0; i < 2; i++) begin
        if (under[i]) begin
          count[i] <= latch[i];
          if (cr_q[i][cia_pkg::CR_ONESHOT]) cr_q[i][cia_pkg::CR_START] <= 1'b0;
        end else if (tick[i]) begin
          count[i] <= count[i] - 16'd1;
        end
        // Register writes win over counting
        if (wr_lo[i]) latch[i][7:0] <= access.wdata;
        if (wr_hi[i]) begin
          latch[i][15:8] <= access.wdata;
          if (!cr_q[i][cia_pkg::CR_START]) count[i] <= {access.wdata, latch[i][7:0]};
        end
        if (wr_cr[i]) begin
          cr_q[i]                   <= access.wdata;
          cr_q[i][cia_pkg::CR_LOAD] <= 1'b0;
          if (access.wdata[cia_pkg::CR_LOAD]) count[i] <= latch[i];
        end
      end
    end
  end

  // One-shot underflow stops the timer for good
  for (genvar g = 0; g < 2; g++) begin : g_oneshot_chk
    assert property (@(posedge clk) disable iff (int_reset)
      under[g] && cr_q[g][cia_pkg::CR_ONESHOT] && !wr_cr[g]
        |=> !cr_q[g][cia_pkg::CR_START] && !under[g]);
  end

endmodule

//--- hw/cia_io_ports.sv
// ====================
// Ports A and B, FLAG input and PC handshake pulse
// Undriven pins read back as inputs and idle high
// ====================
`timescale 1ns/1ps

module cia_io_ports (
  input  logic                 clk,
  input  logic                 int_reset,
  input  cia_pkg::reg_access_t access,
  input  logic [7:0]           pa_in,
  input  logic [7:0]           pb_in,
  output logic [7:0]           pa_out,
  output logic [7:0]           pb_out,
  input  logic                 flag_n,
  output logic                 pc,
  output logic [7:0]           rdata,
  output logic                 flag_event
);

  logic [7:0] pra;
  logic [7:0] prb;
  logic [7:0] ddra;
  logic [7:0] ddrb;
  logic       flag_d;

  assign pa_out = pra | ~ddra;
  assign pb_out = prb | ~ddrb;

  assign flag_event = flag_d & ~flag_n;

  always_comb begin
    case (access.addr)
      cia_pkg::REG_PRA:  rdata = pa_in;
      cia_pkg::REG_PRB:  rdata = pb_in;
      cia_pkg::REG_DDRA: rdata = ddra;
      cia_pkg::REG_DDRB: rdata = ddrb;
      default:           rdata = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      pra    <= 8'h00;
      prb    <= 8'h00;
      ddra   <= 8'h00;
      ddrb   <= 8'h00;
      flag_d <= 1'b1;
      pc     <= 1'b0;
    end else begin
      flag_d <= flag_n;
      // Handshake on any PRB access
      pc <= (access.wr | access.rd) && access.addr == cia_pkg::REG_PRB;
      if (access.wr) begin
        case (access.addr)
          cia_pkg::REG_PRA:  pra  <= access.wdata;
          cia_pkg::REG_PRB:  prb  <= access.wdata;
          cia_pkg::REG_DDRA: ddra <= access.wdata;
          cia_pkg::REG_DDRB: ddrb <= access.wdata;
          default: ;
        endcase
      end
    end
  end

  assert property (@(posedge clk) disable iff (int_reset) pc |=> !pc);

endmodule

//--- hw/cia_apb_decode.sv
// ====================
// APB completer with one fixed wait state per transfer
// Host must hold its signals until pready is seen high
// ====================
`timescale 1ns/1ps

module cia_apb_decode (
  input  logic                clk,
  input  logic                int_reset,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [3:0]          paddr,
  input  logic [7:0]          pwdata,
  output logic [7:0]          prdata,
  output logic                pready,
  output cia_pkg::reg_access_t access,
  input  logic [7:0]          port_rdata,
  input  logic [7:0]          timer_rdata,
  input  logic [7:0]          tod_rdata,
  input  logic [7:0]          icr_rdata
);

  logic       phase;
  logic       strobe;
  logic [7:0] rd_sel;

  // First access cycle only
  assign strobe = psel & penable & ~phase;

  assign access.wr    = strobe & pwrite;
  assign access.rd    = strobe & ~pwrite;
  assign access.addr  = paddr;
  assign access.wdata = pwdata;

  assign pready = phase;

  always_comb begin
    case (paddr[3:2])
      2'b00: rd_sel = port_rdata;
      2'b01: rd_sel = timer_rdata;
      2'b10: rd_sel = tod_rdata;
      default: begin
        if (paddr == cia_pkg::REG_ICR) rd_sel = icr_rdata;
        else if (paddr == cia_pkg::REG_SDR) rd_sel = 8'h00;
        else rd_sel = timer_rdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      phase <= 1'b0;
    end else begin
      phase <= strobe;
    end
  end

  always_ff @(posedge clk) begin
    if (access.rd) prdata <= rd_sel;
  end

  // Strobe only right after a setup cycle, never two in a row
  assert property (@(posedge clk) disable iff (int_reset)
    strobe |-> $past(psel && !penable));

  // pready belongs to the transfer that was strobed just before
  assert property (@(posedge clk) disable iff (int_reset)
    pready |-> $past(strobe) && psel && penable);

endmodule

//--- hw/cia_pkg.sv
// ====================
// Shared definitions for the 6526-style interface adapter
// No serial port: SDR reads 0 and ICR bit 3 never sets
// ====================
package cia_pkg;

  // Register map, classic 6526 order
  localparam logic [3:0] REG_PRA       = 4'h0;
  localparam logic [3:0] REG_PRB       = 4'h1;
  localparam logic [3:0] REG_DDRA      = 4'h2;
  localparam logic [3:0] REG_DDRB      = 4'h3;
  localparam logic [3:0] REG_TA_LO     = 4'h4;
  localparam logic [3:0] REG_TA_HI     = 4'h5;
  localparam logic [3:0] REG_TB_LO     = 4'h6;
  localparam logic [3:0] REG_TB_HI     = 4'h7;
  localparam logic [3:0] REG_TOD_10THS = 4'h8;
  localparam logic [3:0] REG_TOD_SEC   = 4'h9;
  localparam logic [3:0] REG_TOD_MIN   = 4'hA;
  localparam logic [3:0] REG_TOD_HR    = 4'hB;
  localparam logic [3:0] REG_SDR       = 4'hC;
  localparam logic [3:0] REG_ICR       = 4'hD;
  localparam logic [3:0] REG_CRA       = 4'hE;
  localparam logic [3:0] REG_CRB       = 4'hF;

  // Control register bit positions
  localparam int CR_START      = 0;
  localparam int CR_ONESHOT    = 3;
  localparam int CR_LOAD       = 4;
  localparam int CR_INMODE_LO  = 5;
  localparam int CRB_INMODE_HI = 6;
  localparam int CRA_TOD_50HZ  = 7;
  localparam int CRB_ALARM     = 7;

  // ICR source bits
  localparam int IRQ_TA      = 0;
  localparam int IRQ_TB      = 1;
  localparam int IRQ_ALARM   = 2;
  localparam int IRQ_FLAG    = 4;
  localparam int IRQ_SOURCES = 5;

  // TOD input edges per tenth of a second
  localparam logic [2:0] TOD_DIV_60 = 3'd6;
  localparam logic [2:0] TOD_DIV_50 = 3'd5;

  // One-cycle register access, broadcast to every peer
  typedef struct packed {
    logic       wr;
    logic       rd;
    logic [3:0] addr;
    logic [7:0] wdata;
  } reg_access_t;

  typedef struct packed {
    logic ta;
    logic tb;
    logic alarm;
    logic flag;
  } irq_events_t;

  typedef struct packed {
    logic                   set_clr;
    logic [1:0]             unused;
    logic [IRQ_SOURCES-1:0] mask;
  } icr_wr_t;

  typedef struct packed {
    logic                   irq;
    logic [1:0]             unused;
    logic [IRQ_SOURCES-1:0] flags;
  } icr_rd_t;

  // Same ICR byte, mask command on write and status on read
  typedef union packed {
    icr_wr_t wr;
    icr_rd_t rd;
  } icr_word_u;

endpackage
